//--- common/squeeze_pkg.sv
package squeeze_pkg;

	localparam int DATA_W    = 16;	// feature values, signed
	localparam int WGT_W     = 8;	// weights, signed
	localparam int ACC_W     = 40;
	localparam int OUT_SHIFT = 4;	// accumulator scaling before clip
	localparam int ADR_W     = 8;	// wishbone word address

	localparam logic [ADR_W-1:0] ADR_IFM      = 8'h00;
	localparam logic [ADR_W-1:0] ADR_STATUS   = 8'h01;
	localparam logic [ADR_W-1:0] ADR_OFM_BASE = 8'h80;	// lane i at base + i

	typedef struct packed {
		logic                     valid;
		logic                     first;	// channel 0 of a frame
		logic                     last;		// channel CHIN-1 of a frame
		logic signed [DATA_W-1:0] ifm;
	} squeeze_beat_t;

	typedef struct packed {
		logic             cyc;
		logic             stb;
		logic             we;
		logic [ADR_W-1:0] adr;
		logic [31:0]      dat;
		logic [3:0]       sel;
	} wb_req_t;

	typedef struct packed {
		logic        ack;
		logic [31:0] dat;
	} wb_rsp_t;

	// fixed weight pattern, range -15..15
	function automatic logic signed [WGT_W-1:0] weight_of(input int channel, input int lane);
		int v;
		v = (channel * 7 + lane * 13 + 3) % 31 - 15;
		return v[WGT_W-1:0];
	endfunction

endpackage

//--- hdl/weight_rom.sv
`timescale 1ns/100ps

module weight_rom #(
	parameter int N_LANES = 8,
	parameter int CHIN    = 16
) (
	input  logic                                       clk,
	input  logic [$clog2(CHIN)-1:0]                    rom_adr,
	output logic [N_LANES-1:0][squeeze_pkg::WGT_W-1:0] row
);
	import squeeze_pkg::*;

	// one row of N_LANES weights per input channel
	logic [N_LANES-1:0][WGT_W-1:0] table_q [CHIN];

	for (genvar c = 0; c < CHIN; c++) begin : g_ch
		for (genvar l = 0; l < N_LANES; l++) begin : g_lane
			assign table_q[c][l] = weight_of(c, l);	// constant at elaboration
		end
	end

	// registered read, row valid the cycle after rom_adr
	always_ff @(posedge clk) begin
		row <= table_q[rom_adr];
	end

endmodule

//--- squeeze/squeeze_sequencer.sv
`timescale 1ns/100ps

module squeeze_sequencer #(
	parameter int N_LANES = 8,
	parameter int CHIN    = 16
) (
	input  logic                          clk,
	input  logic                          rst,
	input  squeeze_pkg::wb_req_t          wb_req,
	output squeeze_pkg::wb_rsp_t          wb_rsp,
	output logic [squeeze_pkg::ADR_W-1:0] rd_adr,
	input  logic [31:0]                   rd_dat,
	output logic [$clog2(CHIN)-1:0]       rom_adr,
	output squeeze_pkg::squeeze_beat_t    beat
);
	import squeeze_pkg::*;

	localparam int CNT_W = $clog2(CHIN);
	localparam logic [CNT_W-1:0] LAST_CH = CNT_W'(CHIN - 1);

	logic             ack_q;
	logic [31:0]      dat_q;
	logic [CNT_W-1:0] ch_cnt;
	logic [CNT_W-1:0] rom_adr_q;
	squeeze_beat_t    beat_q;
	squeeze_beat_t    beat_d;
	logic             req_new;
	logic             wr_ifm;

	// a request is taken once, ack is never stretched
	assign req_new = wb_req.cyc && wb_req.stb && !ack_q;
	assign wr_ifm  = req_new && wb_req.we && (wb_req.adr == ADR_IFM);

	always_ff @(posedge clk) begin
		if (rst) begin
			ack_q <= 1'b0;
			dat_q <= '0;
		end else begin
			ack_q <= req_new;
			if (req_new && !wb_req.we)
				dat_q <= rd_dat;	// lands in the ack cycle
		end
	end

	// channel position, wraps after the last channel of a frame
	always_ff @(posedge clk) begin
		if (rst)
			ch_cnt <= '0;
		else if (wr_ifm)
			ch_cnt <= (ch_cnt == LAST_CH) ? '0 : ch_cnt + 1'b1;
	end

	always_ff @(posedge clk) begin
		if (wr_ifm)
			rom_adr_q <= ch_cnt;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			beat_q <= '0;
			beat_d <= '0;
		end else begin
			beat_q.valid <= wr_ifm;
			beat_q.first <= (ch_cnt == '0);
			beat_q.last  <= (ch_cnt == LAST_CH);
			beat_q.ifm   <= wb_req.dat[DATA_W-1:0];
			beat_d       <= beat_q;	// one stage to meet the rom row
		end
	end

	assign wb_rsp.ack = ack_q;
	assign wb_rsp.dat = dat_q;
	assign rd_adr     = wb_req.adr;
	assign rom_adr    = rom_adr_q;
	assign beat       = beat_d;

endmodule

//--- squeeze/squeeze_lane.sv
`timescale 1ns/100ps

module squeeze_lane #(
	parameter int LANE = 0
) (
	input  logic                                clk,
	input  logic                                rst,
	input  squeeze_pkg::squeeze_beat_t          beat,
	input  logic signed [squeeze_pkg::WGT_W-1:0] weight,
	output logic signed [squeeze_pkg::ACC_W-1:0] sum,
	output logic                                done
);
	import squeeze_pkg::*;

	logic signed [DATA_W+WGT_W-1:0] prod;
	logic signed [ACC_W-1:0]        prod_ext;

	assign prod     = beat.ifm * weight;
	assign prod_ext = ACC_W'(prod);	// sign extended to accumulator width

	// first channel loads, the rest accumulate
	always_ff @(posedge clk) begin
		if (beat.valid) begin
			if (beat.first)
				sum <= prod_ext;
			else
				sum <= sum + prod_ext;
		end
	end

	always_ff @(posedge clk) begin
		if (rst)
			done <= 1'b0;
		else
			done <= beat.valid && beat.last;	// sum is final in this cycle
	end

endmodule

//--- squeeze/squeeze_collector.sv
`timescale 1ns/100ps

module squeeze_collector #(
	parameter int N_LANES = 8
) (
	input  logic                                       clk,
	input  logic                                       rst,
	input  logic                                       first_seen,
	input  logic [N_LANES-1:0][squeeze_pkg::ACC_W-1:0] sums,
	input  logic                                       done,
	input  logic [squeeze_pkg::ADR_W-1:0]              rd_adr,
	output logic [31:0]                                rd_dat
);
	import squeeze_pkg::*;

	localparam logic signed [ACC_W-1:0] OUT_MAX = ACC_W'((1 << (DATA_W - 1)) - 1);

	logic [N_LANES-1:0][DATA_W-1:0] ofm_q;
	logic [N_LANES-1:0][DATA_W-1:0] ofm_next;
	logic                           done_q;
	logic [7:0]                     frame_cnt;

	// shift, relu, then clip to the positive output range
	function automatic logic [DATA_W-1:0] scale_clip(input logic signed [ACC_W-1:0] acc);
		logic signed [ACC_W-1:0] sh;
		sh = acc >>> OUT_SHIFT;
		if (sh < 0)
			return '0;
		if (sh > OUT_MAX)
			return OUT_MAX[DATA_W-1:0];
		return sh[DATA_W-1:0];
	endfunction

	always_comb begin
		for (int i = 0; i < N_LANES; i++)
			ofm_next[i] = scale_clip(sums[i]);
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			ofm_q     <= '0;
			done_q    <= 1'b0;
			frame_cnt <= '0;
		end else begin
			if (done) begin
				ofm_q     <= ofm_next;
				done_q    <= 1'b1;
				frame_cnt <= frame_cnt + 8'd1;
			end
			// a new frame has begun, even if the old one closes now
			if (first_seen)
				done_q <= 1'b0;
		end
	end

	// read mux, status hides done as soon as a new frame starts
	always_comb begin
		rd_dat = '0;
		if (rd_adr == ADR_STATUS)
			rd_dat = {16'h0, frame_cnt, 7'h0, done_q && !first_seen};
		for (int i = 0; i < N_LANES; i++) begin
			if (rd_adr == ADR_OFM_BASE + ADR_W'(i))
				rd_dat = {{(32 - DATA_W){1'b0}}, ofm_q[i]};	// zero extended
		end
	end

endmodule

//--- hdl/squeeze_top.sv
`timescale 1ns/100ps

module squeeze_top #(
	parameter int N_LANES = 8,
	parameter int CHIN    = 16
) (
	input  logic                 clk,
	input  logic                 rst,
	input  squeeze_pkg::wb_req_t wb_req,
	output squeeze_pkg::wb_rsp_t wb_rsp
);
	import squeeze_pkg::*;

	logic [ADR_W-1:0]               rd_adr;
	logic [31:0]                    rd_dat;
	logic [$clog2(CHIN)-1:0]        rom_adr;
	squeeze_beat_t                  beat;
	logic [N_LANES-1:0][WGT_W-1:0]  row;
	logic [N_LANES-1:0][ACC_W-1:0]  sums;
	logic [N_LANES-1:0]             lane_done;

	squeeze_sequencer #(
		.N_LANES (N_LANES),
		.CHIN    (CHIN)
	) u_seq (
		.clk     (clk),
		.rst     (rst),
		.wb_req  (wb_req),
		.wb_rsp  (wb_rsp),
		.rd_adr  (rd_adr),
		.rd_dat  (rd_dat),
		.rom_adr (rom_adr),
		.beat    (beat)
	);

	weight_rom #(
		.N_LANES (N_LANES),
		.CHIN    (CHIN)
	) u_rom (
		.clk     (clk),
		.rom_adr (rom_adr),
		.row     (row)
	);

	for (genvar i = 0; i < N_LANES; i++) begin : g_lane
		squeeze_lane #(
			.LANE (i)
		) u_lane (
			.clk    (clk),
			.rst    (rst),
			.beat   (beat),
			.weight (row[i]),
			.sum    (sums[i]),
			.done   (lane_done[i])
		);
	end

	// all lanes run in lockstep, lane 0 speaks for them
	squeeze_collector #(
		.N_LANES (N_LANES)
	) u_col (
		.clk        (clk),
		.rst        (rst),
		.first_seen (beat.valid && beat.first),
		.sums       (sums),
		.done       (lane_done[0]),
		.rd_adr     (rd_adr),
		.rd_dat     (rd_dat)
	);

endmodule

//--- dv/tb_squeeze.sv
`timescale 1ns/100ps

module tb_squeeze;
	import squeeze_pkg::*;

	localparam int N_LANES        = 8;
	localparam int CHIN           = 16;
	localparam int TIMEOUT_CYCLES = 6000;	// about six frames of writes and reads, with margin

	typedef struct packed {
		logic [ADR_W-1:0] adr;
		logic [31:0]      got;
		logic [31:0]      exp;
	} read_chk_t;

	logic    clk;
	logic    rst;
	wb_req_t wb_req;
	wb_rsp_t wb_rsp;

	read_chk_t                chk_q [$];
	logic signed [DATA_W-1:0] frame_vals [CHIN];
	logic [31:0]              lcg_state = 32'hfe9d_a203;
	int                       frames_exp = 0;
	int                       cycles = 0;
	int                       n_pushed = 0;
	int                       n_checked = 0;
	int                       test_errs = 0;
	int                       total_errs = 0;
	int                       n_tests = 0;
	int                       n_failed = 0;

	squeeze_top #(
		.N_LANES (N_LANES),
		.CHIN    (CHIN)
	) DUT (
		.clk    (clk),
		.rst    (rst),
		.wb_req (wb_req),
		.wb_rsp (wb_rsp)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	always @(posedge clk) cycles <= cycles + 1;

	function automatic int lane_weight(input int ch, input int lane);
		return (ch * 7 + lane * 13 + 3) % 31 - 15;
	endfunction

	function automatic int weight_sum(input int lane);
		int s;
		s = 0;
		for (int c = 0; c < CHIN; c++)
			s += lane_weight(c, lane);
		return s;
	endfunction

	// dot product over channels, then shift, relu and clip
	function automatic logic [31:0] expected_out(input int lane);
		longint acc;
		acc = 0;
		for (int c = 0; c < CHIN; c++)
			acc += longint'(frame_vals[c]) * lane_weight(c, lane);
		acc = acc >>> OUT_SHIFT;
		if (acc < 0)
			acc = 0;
		else if (acc > 32767)
			acc = 32767;
		return 32'(acc);
	endfunction

	function automatic logic [31:0] status_word(input logic done);
		return {16'h0, 8'(frames_exp), 7'h0, done};
	endfunction

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	task automatic fill_random();
		for (int c = 0; c < CHIN; c++) begin
			lcg_state = lcg_next(lcg_state);
			frame_vals[c] = DATA_W'(int'(lcg_state[31:16] % 4001) - 2000);	// -2000..2000
		end
	endtask

	task automatic fill_const(input logic signed [DATA_W-1:0] v);
		for (int c = 0; c < CHIN; c++)
			frame_vals[c] = v;
	endtask

	task automatic wait_ack();
		do
			@(negedge clk);
		while (!wb_rsp.ack);
	endtask

	task automatic wb_write(input logic [ADR_W-1:0] adr, input logic [31:0] dat);
		wb_req.cyc = 1'b1;
		wb_req.stb = 1'b1;
		wb_req.we  = 1'b1;
		wb_req.adr = adr;
		wb_req.dat = dat;
		wait_ack();
		wb_req.cyc = 1'b0;	// a following call raises it again in the same step
		wb_req.stb = 1'b0;
		wb_req.we  = 1'b0;
	endtask

	task automatic wb_read(input logic [ADR_W-1:0] adr, output logic [31:0] dat);
		wb_req.cyc = 1'b1;
		wb_req.stb = 1'b1;
		wb_req.we  = 1'b0;
		wb_req.adr = adr;
		wait_ack();
		dat = wb_rsp.dat;
		wb_req.cyc = 1'b0;
		wb_req.stb = 1'b0;
	endtask

	task automatic check_read(input logic [ADR_W-1:0] adr, input logic [31:0] exp);
		logic [31:0] got;
		wb_read(adr, got);
		chk_q.push_back({adr, got, exp});
		n_pushed++;
	endtask

	task automatic write_channels(input int lo, input int hi);
		for (int c = lo; c <= hi; c++)
			wb_write(ADR_IFM, 32'(frame_vals[c]));
	endtask

	task automatic run_frame();
		write_channels(0, CHIN - 1);
		frames_exp++;
	endtask

	task automatic wait_done();
		logic [31:0] st;
		int polls;
		st = '0;
		polls = 0;
		while (!st[0] && polls < 10) begin
			wb_read(ADR_STATUS, st);
			polls++;
		end
		assert (st[0]) else begin
			$display("status done bit still low after %0d polls at %0t", polls, $time);
			test_errs++;
		end
	endtask

	task automatic check_outputs();
		for (int i = 0; i < N_LANES; i++)
			check_read(ADR_OFM_BASE + ADR_W'(i), expected_out(i));
		check_read(ADR_STATUS, status_word(1'b1));
	endtask

	task automatic finish_test(input string name);
		wait (n_checked == n_pushed);
		n_tests++;
		if (test_errs != 0)
			n_failed++;
		$display("test %0d %s: %s, %0d errors", n_tests, name,
			(test_errs == 0) ? "ok" : "FAILED", test_errs);
		total_errs += test_errs;
		test_errs = 0;
	endtask

	initial begin : compare
		read_chk_t r;
		forever begin
			wait (n_pushed != n_checked);
			r = chk_q.pop_front();
			assert (r.got == r.exp) else begin
				$display("ERROR at %0t: read of %02h gave %08h, expected %08h",
					$time, r.adr, r.got, r.exp);
				test_errs++;
			end
			n_checked++;
		end
	end

	initial begin : watchdog
		wait (cycles >= TIMEOUT_CYCLES);
		$display("timeout: run still going after %0d cycles", cycles);
		$display("Some tests failed");
		$finish;
	end

	initial begin : stimulus
		rst = 1'b1;
		wb_req = '0;
		wb_req.sel = 4'hf;
		repeat (3) @(negedge clk);
		rst = 1'b0;
		@(negedge clk);

		check_read(ADR_STATUS, 32'h0);
		for (int i = 0; i < N_LANES; i++)
			check_read(ADR_OFM_BASE + ADR_W'(i), 32'h0);
		finish_test("reset state");

		fill_random();
		run_frame();
		wait_done();
		check_outputs();
		finish_test("random frame");

		fill_const(16'sh7fff);
		run_frame();
		wait_done();
		check_outputs();
		for (int l = 0; l < N_LANES; l++)
			if (weight_sum(l) >= 16)	// big enough to reach the clip
				check_read(ADR_OFM_BASE + ADR_W'(l), 32'd32767);
		fill_const(16'sh8000);	// most negative input
		run_frame();
		wait_done();
		check_outputs();
		for (int l = 0; l < N_LANES; l++)
			if (weight_sum(l) > 0)
				check_read(ADR_OFM_BASE + ADR_W'(l), 32'd0);
		finish_test("clipping");

		// three frames with no gap between writes
		repeat (3) begin
			fill_random();
			run_frame();
		end
		wait_done();
		check_outputs();
		finish_test("back to back");

		fill_random();
		write_channels(0, 0);
		check_read(ADR_STATUS, status_word(1'b0));
		write_channels(1, CHIN - 1);
		frames_exp++;
		wait_done();
		check_outputs();
		finish_test("progress");

		check_read(8'h02, 32'h0);
		check_read(8'h40, 32'h0);
		check_read(8'h7f, 32'h0);
		check_read(ADR_OFM_BASE + ADR_W'(N_LANES), 32'h0);
		check_read(8'hff, 32'h0);
		wb_write(ADR_STATUS, 32'h0000_00ff);
		wb_write(ADR_OFM_BASE + 8'h01, 32'h0000_1234);
		check_outputs();
		fill_random();
		write_channels(0, CHIN / 2 - 1);
		wb_write(ADR_STATUS, 32'h0000_5a5a);	// mid-frame, must not move the channel
		wb_write(8'h40, 32'h0000_a5a5);
		write_channels(CHIN / 2, CHIN - 1);
		frames_exp++;
		wait_done();
		check_outputs();
		finish_test("unmapped access");

		$display("%0d tests, %0d failed, %0d reads checked, %0d errors",
			n_tests, n_failed, n_checked, total_errs);
		if (total_errs == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

endmodule

//--- sim.f
common/squeeze_pkg.sv
hdl/weight_rom.sv
squeeze/squeeze_sequencer.sv
squeeze/squeeze_lane.sv
squeeze/squeeze_collector.sv
hdl/squeeze_top.sv
dv/tb_squeeze.sv

//--- Makefile
SRCS := $(wildcard common/*.sv hdl/*.sv squeeze/*.sv dv/*.sv)

.PHONY: all run check clean

all: check

obj_dir/Vtb_squeeze: sim.f $(SRCS)
	verilator --binary --timing -Wno-fatal --top-module tb_squeeze -f sim.f

run: obj_dir/Vtb_squeeze
	./obj_dir/Vtb_squeeze | tee sim.log

check: run
	@grep -q "^All tests passed$$" sim.log && echo "simulation passed" || \
		(echo "simulation failed, see sim.log" && exit 1)

clean:
	rm -rf obj_dir sim.log
